/* verilog.f */
hdl/fetch_pkg.sv
hdl/instr_cache.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
dv/tb_clock_gen.sv
dv/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module fetch_tb -f verilog.f -o fetch_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi

echo "Pass message not found in $LOG"
exit 1

/* dv/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

	import fetch_pkg::*;

	localparam int          ICACHE_LINES    = 16;
	localparam int          IDX_W           = $clog2(ICACHE_LINES);
	localparam int          MEM_WORDS       = 256;
	localparam int          NUM_INSTR       = 400;
	localparam int          RESET_CYCLES    = 5;
	localparam int          WATCHDOG_CYCLES = NUM_INSTR * 60 + RESET_CYCLES;
	localparam logic [31:0] SEED            = 32'h815afe64;

	logic        clock;
	logic        reset;
	logic        stall;
	redirect_t   redirect;
	bus_req_t    bus;
	logic        bus_ready;
	instr_t      bus_rdata;
	fetch_out_t  fetch;
	logic [31:0] hit_count;
	logic [31:0] miss_count;

	// Memory contents and the model's copy of the cache directory
	instr_t      mem [MEM_WORDS];
	logic        model_valid [ICACHE_LINES];
	addr_t       model_tag [ICACHE_LINES];
	addr_t       last_lookup;
	int unsigned exp_hits;
	int unsigned exp_misses;

	tb_clock_gen #(
		.PERIOD_NS (4)
	) u_clock (
		.o_clock (clock)
	);

	fetch_top #(
		.ICACHE_LINES (ICACHE_LINES)
	) u_dut (
		.i_clock      (clock),
		.i_reset      (reset),
		.i_stall      (stall),
		.i_redirect   (redirect),
		.o_bus        (bus),
		.i_bus_ready  (bus_ready),
		.i_bus_rdata  (bus_rdata),
		.o_fetch      (fetch),
		.o_hit_count  (hit_count),
		.o_miss_count (miss_count)
	);

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [71:0] actual,
		input logic [71:0] expected);
		if (actual !== expected) begin
			stop_with_error($sformatf("FAILED at %0t: %s = 0x%0h, expected 0x%0h",
				$time, name, actual, expected));
		end
	endtask

	// Jumps and the four conditional branches
	function automatic logic is_control(input opcode_t opc);
		return opc inside {OPC_JUMP, OPC_BRANCH_EQ, OPC_BRANCH_NE,
			OPC_BRANCH_LT, OPC_BRANCH_GE};
	endfunction

	// Roughly one control transfer in eight words
	function automatic instr_t random_word();
		instr_t  word;
		opcode_t opc;
		word = $urandom;
		opc  = word[31:26];
		if ($urandom % 8 == 0) begin
			case ($urandom % 5)
				0:       opc = OPC_JUMP;
				1:       opc = OPC_BRANCH_EQ;
				2:       opc = OPC_BRANCH_NE;
				3:       opc = OPC_BRANCH_LT;
				default: opc = OPC_BRANCH_GE;
			endcase
		end else begin
			while (is_control(opc)) begin
				word = $urandom;
				opc  = word[31:26];
			end
		end
		word[31:26] = opc;
		return word;
	endfunction

	// Memory wraps every 256 words
	function automatic instr_t mem_word(input addr_t addr);
		return mem[addr[9:2]];
	endfunction

	// Every new pc looked up is a hit or starts a refill
	task automatic model_lookup(input addr_t pc);
		logic [IDX_W-1:0] idx;
		addr_t            line_tag;
		if (pc != last_lookup) begin
			idx      = pc[IDX_W+1:2];
			line_tag = pc >> (IDX_W + 2);
			if (model_valid[idx] && model_tag[idx] == line_tag) begin
				exp_hits = exp_hits + 1;
			end else begin
				exp_misses       = exp_misses + 1;
				model_valid[idx] = 1'b1;
				model_tag[idx]   = line_tag;
			end
			last_lookup = pc;
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		stop_with_error($sformatf("Watchdog expired after %0d cycles, the fetch stage stopped",
			WATCHDOG_CYCLES));
	end

	initial begin
		logic [7:0]  fill_idx;
		logic [31:0] rnd;
		fetch_out_t  fetch_prev;
		addr_t       exp_pc;
		addr_t       mem_addr;
		tag_t        exp_tag;
		tag_t        branch_tag;
		logic        stall_prev;
		logic        branch_pending;
		logic        new_branch;
		logic        mem_busy;
		logic        first_request;
		int unsigned mem_delay;
		int unsigned redirect_delay;
		int unsigned stall_left;
		int unsigned issued;

		reset     = 1'b1;
		stall     = 1'b0;
		redirect  = '0;
		bus_ready = 1'b0;
		bus_rdata = '0;

		void'($urandom(SEED));
		fill_idx = '0;
		repeat (MEM_WORDS) begin
			mem[fill_idx] = random_word();
			fill_idx      = fill_idx + 8'd1;
		end

		model_valid    = '{default: 1'b0};
		model_tag      = '{default: '0};
		last_lookup    = ~RESET_PC;
		exp_hits       = 0;
		exp_misses     = 0;
		exp_pc         = RESET_PC;
		exp_tag        = '0;
		branch_tag     = '0;
		stall_prev     = 1'b0;
		branch_pending = 1'b0;
		mem_busy       = 1'b0;
		first_request  = 1'b1;
		mem_addr       = '0;
		mem_delay      = 0;
		redirect_delay = 0;
		stall_left     = 0;
		issued         = 0;

		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		check_value("o_fetch", 72'(fetch), 72'(0));
		check_value("o_hit_count", 72'(hit_count), 72'(0));
		check_value("o_miss_count", 72'(miss_count), 72'(0));
		check_value("o_bus.request", 72'(bus.request), 72'(0));
		fetch_prev = fetch;

		while (issued < NUM_INSTR) begin
			@(negedge clock);

			// Decode side must see a frozen output under stall
			if (stall_prev) begin
				check_value("o_fetch", 72'(fetch), 72'(fetch_prev));
			end

			new_branch = 1'b0;
			if (fetch.tag != fetch_prev.tag) begin
				if (branch_pending) begin
					stop_with_error($sformatf(
						"Tag changed at %0t before the redirect for tag %0d was sent",
						$time, branch_tag));
				end
				check_value("o_fetch.tag", 72'(fetch.tag), 72'(tag_t'(exp_tag + 8'd1)));
				check_value("o_fetch.pc", 72'(fetch.pc), 72'(exp_pc));
				check_value("o_fetch.instr", 72'(fetch.instr), 72'(mem_word(exp_pc)));
				// Counters are settled here, the next pc is not looked up yet
				model_lookup(exp_pc);
				check_value("o_hit_count", 72'(hit_count), 72'(exp_hits));
				check_value("o_miss_count", 72'(miss_count), 72'(exp_misses));
				exp_tag = fetch.tag;
				issued  = issued + 1;
				if (is_control(fetch.instr[31:26])) begin
					branch_pending = 1'b1;
					new_branch     = 1'b1;
					branch_tag     = fetch.tag;
					redirect_delay = 1 + $urandom % 8;
				end else begin
					exp_pc = exp_pc + 32'd4;
				end
			end

			// Execute stage resolves the branch after a while
			if (branch_pending && !new_branch) begin
				redirect_delay = redirect_delay - 1;
				if (redirect_delay == 0) begin
					rnd              = $urandom;
					exp_pc           = {22'd0, rnd[7:0], 2'b00};
					redirect.tag     = branch_tag;
					redirect.next_pc = exp_pc;
					branch_pending   = 1'b0;
				end
			end

			// Memory side of the refill bus
			if (bus_ready) begin
				bus_ready = 1'b0;
				bus_rdata = $urandom;
				check_value("o_bus.request", 72'(bus.request), 72'(0));
			end else if (bus.request) begin
				if (!mem_busy) begin
					if (first_request) begin
						check_value("o_bus.address", 72'(bus.address), 72'(RESET_PC));
						first_request = 1'b0;
					end
					mem_busy  = 1'b1;
					mem_addr  = bus.address;
					mem_delay = $urandom % 6;
				end else begin
					check_value("o_bus.address", 72'(bus.address), 72'(mem_addr));
				end
				if (mem_delay == 0) begin
					bus_ready = 1'b1;
					bus_rdata = mem_word(mem_addr);
					mem_busy  = 1'b0;
				end else begin
					mem_delay = mem_delay - 1;
				end
			end else if (mem_busy) begin
				stop_with_error($sformatf("Bus request dropped at %0t before ready", $time));
			end

			// Random stall pulses of one to four cycles
			if (stall_left > 0) begin
				stall      = 1'b1;
				stall_left = stall_left - 1;
			end else if ($urandom % 10 == 0) begin
				stall      = 1'b1;
				stall_left = $urandom % 4;
			end else begin
				stall = 1'b0;
			end
			stall_prev = stall;
			fetch_prev = fetch;
		end

		$display("Issued %0d instructions, %0d hits, %0d misses", issued, exp_hits, exp_misses);
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 4
) (
	output logic o_clock
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
	parameter int ICACHE_LINES = 16
) (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_stall,

	// From execute
	input  fetch_pkg::redirect_t  i_redirect,

	// Memory bus
	output fetch_pkg::bus_req_t   o_bus,
	input  logic                  i_bus_ready,
	input  fetch_pkg::instr_t     i_bus_rdata,

	// To decode
	output fetch_pkg::fetch_out_t o_fetch,

	// Cache debug counters
	output logic [31:0]           o_hit_count,
	output logic [31:0]           o_miss_count
);

	import fetch_pkg::*;

	addr_t       lookup_pc;
	cache_resp_t cache_resp;

	fetch_unit u_fetch (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_stall    (i_stall),
		.i_redirect (i_redirect),
		.i_resp     (cache_resp),
		.o_pc       (lookup_pc),
		.o_fetch    (o_fetch)
	);

	instr_cache #(
		.ICACHE_LINES (ICACHE_LINES)
	) u_icache (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_pc         (lookup_pc),
		.o_resp       (cache_resp),
		.o_bus        (o_bus),
		.i_bus_ready  (i_bus_ready),
		.i_bus_rdata  (i_bus_rdata),
		.o_hit_count  (o_hit_count),
		.o_miss_count (o_miss_count)
	);

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_stall,

	// Branch resolution from execute
	input  fetch_pkg::redirect_t   i_redirect,

	// Cache interface
	input  fetch_pkg::cache_resp_t i_resp,
	output fetch_pkg::addr_t       o_pc,

	// Towards decode
	output fetch_pkg::fetch_out_t  o_fetch
);

	import fetch_pkg::*;

	localparam logic ST_RUN         = 1'b0;
	localparam logic ST_WAIT_BRANCH = 1'b1;

	logic       state;
	addr_t      pc;
	fetch_out_t fetch_q;

	opcode_t opcode;
	logic    is_branch;
	logic    resp_match;
	logic    issue;
	logic    redirect_take;
	tag_t    next_tag;

	// Opcode sits at the same bits in every format
	assign opcode = i_resp.data[31:26];

	// Branch predecode
	always_comb begin
		case (opcode)
			OPC_JUMP,
			OPC_BRANCH_EQ,
			OPC_BRANCH_NE,
			OPC_BRANCH_LT,
			OPC_BRANCH_GE: is_branch = 1'b1;
			default:       is_branch = 1'b0;
		endcase
	end

	// Cache answer belongs to the current pc
	assign resp_match = (i_resp.pc == pc);

	assign issue = (state == ST_RUN) && !i_stall && resp_match;

	// Only the redirect for the last issued branch counts
	assign redirect_take = (state == ST_WAIT_BRANCH) && !i_stall &&
		(i_redirect.tag == fetch_q.tag);

	assign next_tag = fetch_q.tag + tag_t'(1);

	// Issue register towards decode
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			fetch_q <= '0;
		end else if (issue) begin
			fetch_q.tag   <= next_tag;
			fetch_q.pc    <= pc;
			fetch_q.instr <= i_resp.data;
		end
	end

	// PC state machine
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_RUN;
			pc    <= RESET_PC;
		end else begin
			case (state)
				ST_RUN: begin
					if (issue) begin
						if (is_branch) begin
							// Hold pc until execute resolves it
							state <= ST_WAIT_BRANCH;
						end else begin
							pc <= pc + 32'd4;
						end
					end
				end
				ST_WAIT_BRANCH: begin
					if (redirect_take) begin
						pc    <= i_redirect.next_pc;
						state <= ST_RUN;
					end
				end
				default: state <= ST_RUN;
			endcase
		end
	end

	assign o_pc    = pc;
	assign o_fetch = fetch_q;

	// PC stays on a word boundary
	a_pc_aligned: assert property (@(posedge i_clock) disable iff (i_reset)
		pc[1:0] == 2'b00);

endmodule

/* hdl/instr_cache.sv */
`timescale 1ns/1ps

module instr_cache #(
	parameter int ICACHE_LINES = 16
) (
	input  logic                  i_clock,
	input  logic                  i_reset,

	// Lookup from the fetch unit
	input  fetch_pkg::addr_t      i_pc,
	output fetch_pkg::cache_resp_t o_resp,

	// Refill bus
	output fetch_pkg::bus_req_t   o_bus,
	input  logic                  i_bus_ready,
	input  fetch_pkg::instr_t     i_bus_rdata,

	// Debug counters
	output logic [31:0]           o_hit_count,
	output logic [31:0]           o_miss_count
);

	import fetch_pkg::*;

	localparam int IDX_W = $clog2(ICACHE_LINES);
	localparam int TAG_W = 32 - IDX_W - 2;

	localparam logic ST_LOOKUP = 1'b0;
	localparam logic ST_REFILL = 1'b1;

	// Line storage
	logic [ICACHE_LINES-1:0] line_valid;
	logic [TAG_W-1:0]        line_tag  [ICACHE_LINES];
	instr_t                  line_data [ICACHE_LINES];

	logic state;

	logic [IDX_W-1:0] lookup_idx;
	logic [TAG_W-1:0] lookup_tag;
	logic [IDX_W-1:0] fill_idx;
	logic [TAG_W-1:0] fill_tag;

	logic new_pc;
	logic lookup_hit;
	logic start_refill;
	logic line_write;

	logic        bus_request;
	addr_t       bus_address;
	cache_resp_t resp_q;
	logic [31:0] hit_count;
	logic [31:0] miss_count;

	// Word address split into index and tag
	assign lookup_idx = i_pc[IDX_W+1:2];
	assign lookup_tag = i_pc[31:IDX_W+2];
	assign fill_idx   = bus_address[IDX_W+1:2];
	assign fill_tag   = bus_address[31:IDX_W+2];

	// Only a pc not yet answered starts a lookup
	assign new_pc     = (i_pc != resp_q.pc);
	assign lookup_hit = line_valid[lookup_idx] && (line_tag[lookup_idx] == lookup_tag);

	assign start_refill = (state == ST_LOOKUP) && new_pc && !lookup_hit;
	assign line_write   = (state == ST_REFILL) && i_bus_ready;

	// Lookup / refill controller
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state       <= ST_LOOKUP;
			bus_request <= 1'b0;
			// Unaligned pc, so nothing matches until the first lookup
			resp_q.pc   <= ~RESET_PC;
			resp_q.data <= '0;
			hit_count   <= '0;
			miss_count  <= '0;
		end else begin
			case (state)
				ST_LOOKUP: begin
					if (new_pc) begin
						if (lookup_hit) begin
							resp_q.pc   <= i_pc;
							resp_q.data <= line_data[lookup_idx];
							hit_count   <= hit_count + 32'd1;
						end else begin
							bus_request <= 1'b1;
							miss_count  <= miss_count + 32'd1;
							state       <= ST_REFILL;
						end
					end
				end
				ST_REFILL: begin
					// Answer straight from the bus word
					if (i_bus_ready) begin
						bus_request <= 1'b0;
						resp_q.pc   <= bus_address;
						resp_q.data <= i_bus_rdata;
						state       <= ST_LOOKUP;
					end
				end
				default: state <= ST_LOOKUP;
			endcase
		end
	end

	// Address held for the whole request
	always_ff @(posedge i_clock) begin
		if (start_refill) begin
			bus_address <= i_pc;
		end
	end

	// Valid bits
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			line_valid <= '0;
		end else if (line_write) begin
			line_valid[fill_idx] <= 1'b1;
		end
	end

	// Tag and data arrays
	always_ff @(posedge i_clock) begin
		if (line_write) begin
			line_tag[fill_idx]  <= fill_tag;
			line_data[fill_idx] <= i_bus_rdata;
		end
	end

	assign o_resp         = resp_q;
	assign o_bus.request  = bus_request;
	assign o_bus.address  = bus_address;
	assign o_hit_count    = hit_count;
	assign o_miss_count   = miss_count;

	// Request and address hold until memory answers
	a_bus_addr_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		bus_request && !i_bus_ready |=> bus_request && $stable(bus_address));

	// Memory raises ready only for an open request
	a_ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_ready |-> bus_request);

endmodule

/* hdl/fetch_pkg.sv */
package fetch_pkg;

	// Basic words of the fetch stage
	typedef logic [31:0] addr_t;
	typedef logic [31:0] instr_t;

	// Sequence tag, wraps around
	typedef logic [7:0] tag_t;

	// Opcode field, bits 31..26 in every instruction format
	typedef logic [5:0] opcode_t;

	// Control transfer opcodes
	localparam opcode_t OPC_JUMP      = 6'h02;
	localparam opcode_t OPC_BRANCH_EQ = 6'h04;
	localparam opcode_t OPC_BRANCH_NE = 6'h05;
	localparam opcode_t OPC_BRANCH_LT = 6'h06;
	localparam opcode_t OPC_BRANCH_GE = 6'h07;

	// First fetch address after reset
	localparam addr_t RESET_PC = 32'h0000_0000;

	// Issued instruction towards decode
	typedef struct packed {
		tag_t   tag;
		addr_t  pc;
		instr_t instr;
	} fetch_out_t;

	// Resolved branch from execute
	typedef struct packed {
		tag_t  tag;
		addr_t next_pc;
	} redirect_t;

	// Refill request towards memory
	typedef struct packed {
		logic  request;
		addr_t address;
	} bus_req_t;

	// Cache answer, pc tells which lookup it belongs to
	typedef struct packed {
		addr_t  pc;
		instr_t data;
	} cache_resp_t;

endpackage
